//--- bench/tb_vectors.svh
// columns: kind, we, word address, sel, wdata, switch value,
//          expected rdata, expected led_o, expected irq_o
// RAM entries take random write data and check reads against the shadow copy

localparam logic [1:0] K_BUS = 2'd0;
localparam logic [1:0] K_RAM = 2'd1;
localparam logic [1:0] K_SW = 2'd2;

function automatic logic [sof_pkg::ADDR_W-1:0] ram_addr(input logic [25:0] off);
	return {sof_pkg::REGION_RAM, off};
endfunction

function automatic logic [sof_pkg::ADDR_W-1:0] dev_addr(input logic [7:0] slot,
		input logic [5:0] num);
	return {sof_pkg::REGION_DEV, 12'h000, slot, num};
endfunction

task automatic load_vectors();
	logic [7:0] bs;
	bs = sof_pkg::DEV_SLOT_BOARD;
	add_vec(K_RAM, 1, ram_addr(26'h010), 4'hF, 0, 0, 0, 16'h0000, 0);
	add_vec(K_RAM, 1, ram_addr(26'h011), 4'hF, 0, 0, 0, 16'h0000, 0);
	add_vec(K_RAM, 1, ram_addr(26'h200), 4'hF, 0, 0, 0, 16'h0000, 0);
	add_vec(K_RAM, 1, ram_addr(26'h3FF), 4'hF, 0, 0, 0, 16'h0000, 0);
	add_vec(K_RAM, 1, ram_addr(26'h010), 4'h3, 0, 0, 0, 16'h0000, 0);
	add_vec(K_RAM, 1, ram_addr(26'h011), 4'hC, 0, 0, 0, 16'h0000, 0);
	add_vec(K_RAM, 1, ram_addr(26'h200), 4'h5, 0, 0, 0, 16'h0000, 0);
	add_vec(K_RAM, 0, ram_addr(26'h010), 4'hF, 0, 0, 0, 16'h0000, 0);
	add_vec(K_RAM, 0, ram_addr(26'h011), 4'hF, 0, 0, 0, 16'h0000, 0);
	add_vec(K_RAM, 0, ram_addr(26'h200), 4'hF, 0, 0, 0, 16'h0000, 0);
	add_vec(K_RAM, 0, ram_addr(26'h3FF), 4'hF, 0, 0, 0, 16'h0000, 0);
	// unmapped regions
	add_vec(K_BUS, 1, {4'h5, 26'h0000040}, 4'hF, 32'hDEAD_BEEF, 0, 0, 16'h0000, 0);
	add_vec(K_BUS, 0, {4'h5, 26'h0000040}, 4'hF, 0, 0, 32'h0, 16'h0000, 0);
	add_vec(K_BUS, 0, {4'h7, 26'h1234567}, 4'hF, 0, 0, 32'h0, 16'h0000, 0);
	// empty slots and a board register past the last one
	add_vec(K_BUS, 0, dev_addr(8'd5, 6'd0), 4'hF, 0, 0, 32'h0, 16'h0000, 0);
	add_vec(K_BUS, 1, dev_addr(8'd0, sof_pkg::BOARD_REG_LED), 4'hF, 32'h0000_FFFF, 0, 0,
		16'h0000, 0);
	add_vec(K_BUS, 0, dev_addr(8'd0, sof_pkg::BOARD_REG_LED), 4'hF, 0, 0, 32'h0, 16'h0000, 0);
	add_vec(K_BUS, 0, dev_addr(bs, 6'd9), 4'hF, 0, 0, 32'h0, 16'h0000, 0);
	// LED byte lanes
	add_vec(K_BUS, 1, dev_addr(bs, sof_pkg::BOARD_REG_LED), 4'h1, 32'h0000_12A5, 0, 0,
		16'h00A5, 0);
	add_vec(K_BUS, 1, dev_addr(bs, sof_pkg::BOARD_REG_LED), 4'h2, 32'h0000_3C77, 0, 0,
		16'h3CA5, 0);
	add_vec(K_BUS, 1, dev_addr(bs, sof_pkg::BOARD_REG_LED), 4'h4, 32'h00FF_0000, 0, 0,
		16'h3CA5, 0);
	add_vec(K_BUS, 0, dev_addr(bs, sof_pkg::BOARD_REG_LED), 4'hF, 0, 0, 32'h0000_3CA5,
		16'h3CA5, 0);
	add_vec(K_BUS, 0, dev_addr(bs, sof_pkg::BOARD_REG_IRQ_EN), 4'hF, 0, 0, 32'h0, 16'h3CA5, 0);
	// switches and the change interrupt
	add_vec(K_SW, 0, 0, 0, 0, 16'hBEEF, 0, 16'h3CA5, 0);
	add_vec(K_BUS, 0, dev_addr(bs, sof_pkg::BOARD_REG_SWITCH), 4'hF, 0, 0, 32'h0000_BEEF,
		16'h3CA5, 0);
	add_vec(K_BUS, 0, dev_addr(bs, sof_pkg::BOARD_REG_IRQ_STAT), 4'hF, 0, 0, 32'h1, 16'h3CA5, 0);
	add_vec(K_BUS, 1, dev_addr(bs, sof_pkg::BOARD_REG_IRQ_EN), 4'h1, 32'h1, 0, 0, 16'h3CA5, 1);
	add_vec(K_BUS, 0, dev_addr(bs, sof_pkg::BOARD_REG_IRQ_EN), 4'hF, 0, 0, 32'h1, 16'h3CA5, 1);
	add_vec(K_BUS, 1, dev_addr(bs, sof_pkg::BOARD_REG_IRQ_STAT), 4'h1, 32'h1, 0, 0, 16'h3CA5, 0);
	add_vec(K_BUS, 0, dev_addr(bs, sof_pkg::BOARD_REG_IRQ_STAT), 4'hF, 0, 0, 32'h0, 16'h3CA5, 0);
	add_vec(K_SW, 0, 0, 0, 0, 16'h0001, 0, 16'h3CA5, 1);
	add_vec(K_BUS, 0, dev_addr(bs, sof_pkg::BOARD_REG_SWITCH), 4'hF, 0, 0, 32'h0000_0001,
		16'h3CA5, 1);
	add_vec(K_BUS, 1, dev_addr(bs, sof_pkg::BOARD_REG_IRQ_STAT), 4'h1, 32'h0, 0, 0, 16'h3CA5, 1);
	add_vec(K_BUS, 1, dev_addr(bs, sof_pkg::BOARD_REG_IRQ_STAT), 4'h1, 32'h1, 0, 0, 16'h3CA5, 0);
	add_vec(K_BUS, 1, dev_addr(bs, sof_pkg::BOARD_REG_IRQ_EN), 4'h1, 32'h0, 0, 0, 16'h3CA5, 0);
	add_vec(K_SW, 0, 0, 0, 0, 16'h00F0, 0, 16'h3CA5, 0);
	add_vec(K_BUS, 0, dev_addr(bs, sof_pkg::BOARD_REG_IRQ_STAT), 4'hF, 0, 0, 32'h1, 16'h3CA5, 0);
endtask

//--- bench/tb_sof.sv
`timescale 1ns/1ps

module tb_sof;

	typedef struct packed {
		logic [1:0] kind;
		logic we;
		logic [sof_pkg::ADDR_W-1:0] addr;
		logic [sof_pkg::SEL_W-1:0] sel;
		logic [sof_pkg::DATA_W-1:0] wdata;
		logic [sof_pkg::SWITCH_W-1:0] sw;
		logic [sof_pkg::DATA_W-1:0] exp_rdata;
		logic [sof_pkg::SWITCH_W-1:0] exp_led;
		logic exp_irq;
	} vec_t;

	logic clk_cpu;
	logic rst_n_i;
	logic cyc_i;
	logic stb_i;
	logic we_i;
	logic [sof_pkg::ADDR_W-1:0] addr_i;
	logic [sof_pkg::SEL_W-1:0] sel_i;
	logic [sof_pkg::DATA_W-1:0] wdata_i;
	logic [sof_pkg::DATA_W-1:0] rdata_o;
	logic ack_o;
	logic [sof_pkg::SWITCH_W-1:0] switch_i;
	logic [sof_pkg::SWITCH_W-1:0] led_o;
	logic irq_o;

	vec_t vecs [64];
	int num_vecs;
	int cycle_cnt;
	int err_cnt;
	int pass_cnt;
	int fail_cnt;
	integer seed;
	// expected RAM contents
	logic [sof_pkg::DATA_W-1:0] shadow [1024];

	sof_top dut0 (
		.clk_cpu(clk_cpu),
		.rst_n_i(rst_n_i),
		.cyc_i(cyc_i),
		.stb_i(stb_i),
		.we_i(we_i),
		.addr_i(addr_i),
		.sel_i(sel_i),
		.wdata_i(wdata_i),
		.rdata_o(rdata_o),
		.ack_o(ack_o),
		.switch_i(switch_i),
		.led_o(led_o),
		.irq_o(irq_o)
	);

	always #4 clk_cpu = ~clk_cpu;

	always @(posedge clk_cpu) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= 20 * num_vecs + 50) begin
			$display("timeout: run stopped after %0d cycles without finishing", cycle_cnt);
			$display("sim failed");
			$finish;
		end
	end

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			$display("MISMATCH at %0t: %s expected %h, got %h", $time, name, exp, act);
			err_cnt = err_cnt + 1;
		end
	endtask

	task automatic add_vec(input logic [1:0] kind, input logic we,
			input logic [sof_pkg::ADDR_W-1:0] addr, input logic [sof_pkg::SEL_W-1:0] sel,
			input logic [31:0] wdata, input logic [15:0] sw, input logic [31:0] exp_rdata,
			input logic [15:0] exp_led, input logic exp_irq);
		vecs[num_vecs] = {kind, we, addr, sel, wdata, sw, exp_rdata, exp_led, exp_irq};
		num_vecs = num_vecs + 1;
	endtask

	// byte lanes with sel set take the new data
	function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
			input logic [31:0] new_word, input logic [3:0] sel);
		logic [31:0] res;
		res = old_word;
		for (int b = 0; b < 4; b++) begin
			if (sel[b]) begin
				res[8*b +: 8] = new_word[8*b +: 8];
			end
		end
		return res;
	endfunction

	// one classic cycle, held until ack
	task automatic bus_access(input logic we, input logic [sof_pkg::ADDR_W-1:0] addr,
			input logic [3:0] sel, input logic [31:0] wdata,
			output logic [31:0] rdata, output int cycles);
		@(posedge clk_cpu);
		#1;
		cyc_i = 1'b1;
		stb_i = 1'b1;
		we_i = we;
		addr_i = addr;
		sel_i = sel;
		wdata_i = wdata;
		cycles = 0;
		do begin
			@(posedge clk_cpu);
			#1;
			cycles = cycles + 1;
		end while (!ack_o);
		rdata = rdata_o;
		// keep the request up through the edge that samples ack
		@(posedge clk_cpu);
		#1;
		cyc_i = 1'b0;
		stb_i = 1'b0;
		we_i = 1'b0;
	endtask

	`include "tb_vectors.svh"

	initial begin
		int errs_before;
		int cycles;
		logic [31:0] rd;
		logic [31:0] wd;
		logic [9:0] idx;
		string what;
		clk_cpu = 1'b0;
		rst_n_i = 1'b0;
		cyc_i = 1'b0;
		stb_i = 1'b0;
		we_i = 1'b0;
		addr_i = '0;
		sel_i = '0;
		wdata_i = '0;
		switch_i = '0;
		seed = 32'h320e_31dc;
		err_cnt = 0;
		pass_cnt = 0;
		fail_cnt = 0;
		cycle_cnt = 0;
		num_vecs = 0;
		load_vectors();
		repeat (2) @(posedge clk_cpu);
		#1;
		rst_n_i = 1'b1;
		check_val("ack_o", 32'd0, {31'd0, ack_o});
		check_val("irq_o", 32'd0, {31'd0, irq_o});
		check_val("led_o", 32'd0, {16'd0, led_o});
		if (err_cnt == 0) begin
			pass_cnt = pass_cnt + 1;
			$display("reset values: ok");
		end else begin
			fail_cnt = fail_cnt + 1;
			$display("reset values: FAILED");
		end
		for (int i = 0; i < num_vecs; i++) begin
			errs_before = err_cnt;
			if (vecs[i].kind == K_SW) begin
				@(posedge clk_cpu);
				#1;
				switch_i = vecs[i].sw;
				// two sync flops, the register, then the status bit
				repeat (5) @(posedge clk_cpu);
				#1;
				what = "switch set";
			end else begin
				wd = vecs[i].wdata;
				if (vecs[i].kind == K_RAM && vecs[i].we) begin
					wd = $random(seed);
				end
				bus_access(vecs[i].we, vecs[i].addr, vecs[i].sel, wd, rd, cycles);
				check_val("ack cycles", 32'd1, cycles);
				idx = vecs[i].addr[9:0];
				if (vecs[i].kind == K_RAM && vecs[i].we) begin
					shadow[idx] = merge_bytes(shadow[idx], wd, vecs[i].sel);
				end else if (vecs[i].kind == K_RAM) begin
					check_val("rdata_o", shadow[idx], rd);
				end else if (!vecs[i].we) begin
					check_val("rdata_o", vecs[i].exp_rdata, rd);
				end
				what = vecs[i].we ? "write" : "read";
			end
			check_val("led_o", {16'd0, vecs[i].exp_led}, {16'd0, led_o});
			check_val("irq_o", {31'd0, vecs[i].exp_irq}, {31'd0, irq_o});
			if (err_cnt == errs_before) begin
				pass_cnt = pass_cnt + 1;
				$display("entry %0d %s addr %h: ok", i, what, vecs[i].addr);
			end else begin
				fail_cnt = fail_cnt + 1;
				$display("entry %0d %s addr %h: FAILED", i, what, vecs[i].addr);
			end
		end
		$display("summary: %0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
		if (fail_cnt == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

//--- project.f
+incdir+bench
rtl/sof_pkg.sv
rtl/wb_if.sv
rtl/dev_if.sv
rtl/wb_slave_mux.sv
rtl/wb_ram.sv
rtl/dev_adapter.sv
rtl/board_regs.sv
rtl/sof_top.sv
bench/tb_sof.sv

//--- rtl/board_regs.sv
`timescale 1ns/1ps

module board_regs (
	input logic clk_cpu,
	input logic rst_n_i,
	dev_if.device dev,
	input logic [sof_pkg::SWITCH_W-1:0] switch_i,
	output logic [sof_pkg::SWITCH_W-1:0] led_o,
	output logic irq_o
);

	logic [sof_pkg::SWITCH_W-1:0] sw_meta;
	logic [sof_pkg::SWITCH_W-1:0] sw_sync;
	logic [sof_pkg::SWITCH_W-1:0] sw_reg;
	logic sw_chg;
	logic irq_stat;
	logic irq_en;
	logic req;
	logic wr;
	logic [sof_pkg::DATA_W-1:0] rd_word;

	assign req = dev.cs && !dev.ack;
	assign wr = req && dev.we;

	// two-flop synchroniser, then the readable copy
	always_ff @(posedge clk_cpu or negedge rst_n_i) begin
		if (!rst_n_i) begin
			sw_meta <= '0;
			sw_sync <= '0;
			sw_reg <= '0;
			sw_chg <= 1'b0;
		end else begin
			sw_meta <= switch_i;
			sw_sync <= sw_meta;
			sw_reg <= sw_sync;
			sw_chg <= (sw_sync != sw_reg);
		end
	end

	always_ff @(posedge clk_cpu or negedge rst_n_i) begin
		if (!rst_n_i) begin
			led_o <= '0;
			irq_en <= 1'b0;
			irq_stat <= 1'b0;
			dev.ack <= 1'b0;
		end else begin
			dev.ack <= req;
			if (wr && dev.reg_addr == sof_pkg::BOARD_REG_LED) begin
				if (dev.sel[0]) begin
					led_o[7:0] <= dev.wdata[7:0];
				end
				if (dev.sel[1]) begin
					led_o[15:8] <= dev.wdata[15:8];
				end
			end
			if (wr && dev.reg_addr == sof_pkg::BOARD_REG_IRQ_EN && dev.sel[0]) begin
				irq_en <= dev.wdata[0];
			end
			// a new change wins over a clear in the same cycle
			if (sw_chg) begin
				irq_stat <= 1'b1;
			end else if (wr && dev.reg_addr == sof_pkg::BOARD_REG_IRQ_STAT
					&& dev.sel[0] && dev.wdata[0]) begin
				irq_stat <= 1'b0;
			end
		end
	end

	always_comb begin
		case (dev.reg_addr)
			sof_pkg::BOARD_REG_SWITCH:
				rd_word = {{(sof_pkg::DATA_W-sof_pkg::SWITCH_W){1'b0}}, sw_reg};
			sof_pkg::BOARD_REG_LED:
				rd_word = {{(sof_pkg::DATA_W-sof_pkg::SWITCH_W){1'b0}}, led_o};
			sof_pkg::BOARD_REG_IRQ_STAT:
				rd_word = {{(sof_pkg::DATA_W-1){1'b0}}, irq_stat};
			sof_pkg::BOARD_REG_IRQ_EN:
				rd_word = {{(sof_pkg::DATA_W-1){1'b0}}, irq_en};
			default:
				rd_word = '0;
		endcase
	end

	always_ff @(posedge clk_cpu) begin
		if (req) begin
			dev.rdata <= rd_word;
		end
	end

	assign irq_o = irq_stat && irq_en;

endmodule

//--- rtl/dev_adapter.sv
`timescale 1ns/1ps

module dev_adapter (
	input logic clk_cpu,
	input logic rst_n_i,
	wb_if.slave bus,
	dev_if.adapter board
);

	logic hit_board;
	logic empty_req;
	logic empty_ack;

	assign hit_board = (bus.addr.dev.slot == sof_pkg::DEV_SLOT_BOARD);

	assign board.cs = bus.cyc && bus.stb && hit_board;
	assign board.reg_addr = bus.addr.dev.reg_num;
	assign board.sel = bus.sel;
	assign board.we = bus.we;
	assign board.wdata = bus.wdata;

	// slots with no device behind them
	assign empty_req = bus.cyc && bus.stb && !hit_board;

	always_ff @(posedge clk_cpu or negedge rst_n_i) begin
		if (!rst_n_i) begin
			empty_ack <= 1'b0;
		end else begin
			empty_ack <= empty_req && !empty_ack;
		end
	end

	always_comb begin
		if (hit_board) begin
			bus.rdata = board.rdata;
			bus.ack = board.ack;
		end else begin
			bus.rdata = '0;
			bus.ack = empty_ack;
		end
	end

	// the address is held until ack, so a board access never overlaps an empty-slot answer
	a_slot_excl: assert property (@(posedge clk_cpu) disable iff (!rst_n_i)
		board.cs |-> !empty_ack);

endmodule

//--- rtl/dev_if.sv
`timescale 1ns/1ps

interface dev_if;

	logic cs;
	logic [sof_pkg::REG_NUM_W-1:0] reg_addr;
	logic [sof_pkg::SEL_W-1:0] sel;
	logic we;
	logic [sof_pkg::DATA_W-1:0] wdata;
	logic [sof_pkg::DATA_W-1:0] rdata;
	logic ack;

	// cs is combinational from the bus strobe, ack comes back registered
	modport adapter (
		output cs, reg_addr, sel, we, wdata,
		input rdata, ack
	);

	modport device (
		input cs, reg_addr, sel, we, wdata,
		output rdata, ack
	);

endinterface

//--- rtl/sof_pkg.sv
package sof_pkg;

	// bus widths
	localparam int DATA_W = 32;
	localparam int SEL_W = 4;
	localparam int ADDR_W = 30;
	localparam int REG_NUM_W = 6;

	// top four address bits pick the region
	localparam logic [3:0] REGION_RAM = 4'h0;
	localparam logic [3:0] REGION_DEV = 4'hF;

	localparam logic [7:0] DEV_SLOT_BOARD = 8'd2;

	// word offsets inside the board slot
	localparam logic [REG_NUM_W-1:0] BOARD_REG_SWITCH = 6'd0;
	localparam logic [REG_NUM_W-1:0] BOARD_REG_LED = 6'd1;
	localparam logic [REG_NUM_W-1:0] BOARD_REG_IRQ_STAT = 6'd2;
	localparam logic [REG_NUM_W-1:0] BOARD_REG_IRQ_EN = 6'd3;

	localparam int SWITCH_W = 16;

	// word address, seen either as region + RAM offset or as region + slot + register
	typedef union packed {
		struct packed {
			logic [3:0] region;
			logic [ADDR_W-5:0] offset;
		} rgn;
		struct packed {
			logic [3:0] region;
			logic [11:0] unused;
			logic [7:0] slot;
			logic [REG_NUM_W-1:0] reg_num;
		} dev;
	} bus_addr_u;

endpackage

//--- rtl/sof_top.sv
`timescale 1ns/1ps

module sof_top (
	input logic clk_cpu,
	input logic rst_n_i,
	input logic cyc_i,
	input logic stb_i,
	input logic we_i,
	input logic [sof_pkg::ADDR_W-1:0] addr_i,
	input logic [sof_pkg::SEL_W-1:0] sel_i,
	input logic [sof_pkg::DATA_W-1:0] wdata_i,
	output logic [sof_pkg::DATA_W-1:0] rdata_o,
	output logic ack_o,
	input logic [sof_pkg::SWITCH_W-1:0] switch_i,
	output logic [sof_pkg::SWITCH_W-1:0] led_o,
	output logic irq_o
);

	wb_if ram_bus ();
	wb_if dev_bus ();
	dev_if board_dev ();

	wb_slave_mux u_mux (
		.clk_cpu(clk_cpu),
		.rst_n_i(rst_n_i),
		.cyc_i(cyc_i),
		.stb_i(stb_i),
		.we_i(we_i),
		.addr_i(addr_i),
		.sel_i(sel_i),
		.wdata_i(wdata_i),
		.rdata_o(rdata_o),
		.ack_o(ack_o),
		.ram_bus(ram_bus.master),
		.dev_bus(dev_bus.master)
	);

	wb_ram #(
		.RAM_WORDS(1024)
	) u_ram (
		.clk_cpu(clk_cpu),
		.rst_n_i(rst_n_i),
		.bus(ram_bus.slave)
	);

	dev_adapter u_adapter (
		.clk_cpu(clk_cpu),
		.rst_n_i(rst_n_i),
		.bus(dev_bus.slave),
		.board(board_dev.adapter)
	);

	// board device sits in slot 2
	board_regs u_board (
		.clk_cpu(clk_cpu),
		.rst_n_i(rst_n_i),
		.dev(board_dev.device),
		.switch_i(switch_i),
		.led_o(led_o),
		.irq_o(irq_o)
	);

endmodule

//--- rtl/wb_if.sv
`timescale 1ns/1ps

interface wb_if;

	logic cyc;
	logic stb;
	logic we;
	logic [sof_pkg::SEL_W-1:0] sel;
	sof_pkg::bus_addr_u addr;
	logic [sof_pkg::DATA_W-1:0] wdata;
	logic [sof_pkg::DATA_W-1:0] rdata;
	logic ack;

	modport master (
		output cyc, stb, we, sel, addr, wdata,
		input rdata, ack
	);

	modport slave (
		input cyc, stb, we, sel, addr, wdata,
		output rdata, ack
	);

endinterface

//--- rtl/wb_ram.sv
`timescale 1ns/1ps

module wb_ram #(
	parameter int RAM_WORDS = 1024
) (
	input logic clk_cpu,
	input logic rst_n_i,
	wb_if.slave bus
);

	logic [sof_pkg::DATA_W-1:0] mem [RAM_WORDS];
	logic [$clog2(RAM_WORDS)-1:0] idx;
	logic req;

	// upper offset bits alias
	assign idx = bus.addr.rgn.offset[$clog2(RAM_WORDS)-1:0];
	assign req = bus.cyc && bus.stb && !bus.ack;

	always_ff @(posedge clk_cpu) begin
		if (req) begin
			if (bus.we) begin
				for (int i = 0; i < sof_pkg::SEL_W; i++) begin
					if (bus.sel[i]) begin
						mem[idx][8*i +: 8] <= bus.wdata[8*i +: 8];
					end
				end
			end
			bus.rdata <= mem[idx];
		end
	end

	always_ff @(posedge clk_cpu or negedge rst_n_i) begin
		if (!rst_n_i) begin
			bus.ack <= 1'b0;
		end else begin
			bus.ack <= req;
		end
	end

endmodule

//--- rtl/wb_slave_mux.sv
`timescale 1ns/1ps

module wb_slave_mux (
	input logic clk_cpu,
	input logic rst_n_i,
	input logic cyc_i,
	input logic stb_i,
	input logic we_i,
	input logic [sof_pkg::ADDR_W-1:0] addr_i,
	input logic [sof_pkg::SEL_W-1:0] sel_i,
	input logic [sof_pkg::DATA_W-1:0] wdata_i,
	output logic [sof_pkg::DATA_W-1:0] rdata_o,
	output logic ack_o,
	wb_if.master ram_bus,
	wb_if.master dev_bus
);

	sof_pkg::bus_addr_u addr;
	logic hit_ram;
	logic hit_dev;
	logic miss_req;
	logic miss_ack;

	assign addr = addr_i;
	assign hit_ram = (addr.rgn.region == sof_pkg::REGION_RAM);
	assign hit_dev = (addr.rgn.region == sof_pkg::REGION_DEV);
	assign miss_req = cyc_i && stb_i && !hit_ram && !hit_dev;

	assign ram_bus.cyc = cyc_i && hit_ram;
	assign ram_bus.stb = stb_i && hit_ram;
	assign ram_bus.we = we_i;
	assign ram_bus.sel = sel_i;
	assign ram_bus.addr = addr;
	assign ram_bus.wdata = wdata_i;

	assign dev_bus.cyc = cyc_i && hit_dev;
	assign dev_bus.stb = stb_i && hit_dev;
	assign dev_bus.we = we_i;
	assign dev_bus.sel = sel_i;
	assign dev_bus.addr = addr;
	assign dev_bus.wdata = wdata_i;

	// unmapped region still completes the cycle
	always_ff @(posedge clk_cpu or negedge rst_n_i) begin
		if (!rst_n_i) begin
			miss_ack <= 1'b0;
		end else begin
			miss_ack <= miss_req && !miss_ack;
		end
	end

	always_comb begin
		if (hit_ram) begin
			rdata_o = ram_bus.rdata;
			ack_o = ram_bus.ack;
		end else if (hit_dev) begin
			rdata_o = dev_bus.rdata;
			ack_o = dev_bus.ack;
		end else begin
			rdata_o = '0;
			ack_o = miss_ack;
		end
	end

	// no slave may answer outside a bus cycle
	a_ack_in_cyc: assert property (@(posedge clk_cpu) disable iff (!rst_n_i)
		ack_o |-> cyc_i);

endmodule
